/* hw/binHistogram.sv */
`timescale 1ns/10ps

module binHistogram
    import sifhParamsPkg::*;
    import sifhBusPkg::*;
#(
    // 0 for the aligned histogram, HALF_BIN for the shifted one
    parameter int BIN_OFFSET = 0
)
(
    input  logic          clk,
    input  logic          arstN,
    input  taggedSample_t sample,
    input  logic          frameEnd,
    output winnerSet_t    winners
);

    // timestamp plus offset needs one extra bit
    typedef logic [TIME_BITS:0] wideTime_t;

    wideTime_t  offsetTime;
    binIdx_t    hitBin;
    winnerSet_t winnersNext;

    // per pixel bin counters
    binCount_t binCnt     [PIXEL_NUM][BIN_NUM];
    binCount_t binCntNext [PIXEL_NUM][BIN_NUM];

    // move the bin edges down by the offset, then take the bin number
    assign offsetTime = {1'b0, sample.stamp} + wideTime_t'(BIN_OFFSET);
    assign hitBin     = binIdx_t'(offsetTime >> BIN_SHIFT);

    // counts as they will be after this edge
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                binCntNext[p][b] = binCnt[p][b];
                if (sample.valid && sample.pixel == pixelIdx_t'(p) &&
                    hitBin == binIdx_t'(b)) begin
                    // saturate instead of wrapping
                    if (binCnt[p][b] != '1) begin
                        binCntNext[p][b] = binCnt[p][b] + 1'b1;
                    end
                end
            end
        end
    end

    // winner search per pixel on the next-state counts,
    // so the last sample of the frame is seen at frame end
    always_comb begin
        binWinner_t best;
        winnersNext = '0;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            best.bin   = '0;
            best.count = binCntNext[p][0];
            for (int b = 1; b < BIN_NUM; b++) begin
                // strictly greater keeps the lowest index on ties
                if (binCntNext[p][b] > best.count) begin
                    best.bin   = binIdx_t'(b);
                    best.count = binCntNext[p][b];
                end
            end
            winnersNext[p] = best;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            winners <= '0;
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < BIN_NUM; b++) begin
                    binCnt[p][b] <= '0;
                end
            end
        end else if (frameEnd) begin
            // latch the row and start the next frame from empty bins
            winners <= winnersNext;
            for (int p = 0; p < PIXEL_NUM; p++) begin
                for (int b = 0; b < BIN_NUM; b++) begin
                    binCnt[p][b] <= '0;
                end
            end
        end else begin
            binCnt <= binCntNext;
        end
    end

    // aligned bins stop below 1024, so bin 8 must stay empty
    generate
        if (BIN_OFFSET == 0) begin : gAlignedCheck
            for (genvar p = 0; p < PIXEL_NUM; p++) begin : gPixel
                topBinEmpty: assert property (@(posedge clk) disable iff (!arstN)
                    binCnt[p][BIN_NUM-1] == '0);
            end
        end
    endgenerate

endmodule

/* hw/peakResolver.sv */
`timescale 1ns/10ps

module peakResolver
    import sifhParamsPkg::*;
    import sifhBusPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       frameEnd,
    input  winnerSet_t aligned,
    input  winnerSet_t shifted,
    output peakSet_t   peakResult,
    output logic       peakValid
);

    typedef logic [TIME_BITS:0] wideTime_t;

    // frame end delayed until the histogram winners are settled
    logic frameEndDly;

    // first stage holds which histogram won and its bin
    logic                 choiceValid;
    logic [PIXEL_NUM-1:0] useShifted;
    binIdx_t              selBin [PIXEL_NUM];

    peakSet_t peakNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            frameEndDly <= 1'b0;
            choiceValid <= 1'b0;
        end else begin
            frameEndDly <= frameEnd;
            choiceValid <= frameEndDly;
        end
    end

    // compare counts per pixel
    // aligned wins ties, the shifted bin only helps on a clear gain
    always_ff @(posedge clk) begin
        if (frameEndDly) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                useShifted[p] <= shifted[p].count > aligned[p].count;
                selBin[p]     <= (shifted[p].count > aligned[p].count) ?
                                 shifted[p].bin : aligned[p].bin;
            end
        end
    end

    // turn the chosen bin into a time
    always_comb begin
        wideTime_t wide;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            if (useShifted[p]) begin
                // shifted bin n is centred on n*128
                wide = wideTime_t'(selBin[p]) << BIN_SHIFT;
            end else begin
                // aligned bin centre
                wide = (wideTime_t'(selBin[p]) << BIN_SHIFT) + wideTime_t'(HALF_BIN);
            end
            // shifted bin 8 would land at 1024
            if (wide > wideTime_t'(TIME_MAX)) begin
                wide = wideTime_t'(TIME_MAX);
            end
            peakNext[p] = timestamp_t'(wide);
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            peakResult <= '0;
            peakValid  <= 1'b0;
        end else begin
            peakValid <= choiceValid;
            if (choiceValid) begin
                peakResult <= peakNext;
            end
        end
    end

    // one frame end upstream gives one single-cycle pulse here
    validIsPulse: assert property (@(posedge clk) disable iff (!arstN)
        peakValid |=> !peakValid);

endmodule

/* hw/sampleSequencer.sv */
`timescale 1ns/10ps

module sampleSequencer
    import sifhParamsPkg::*;
    import sifhBusPkg::*;
(
    input  logic          clk,
    input  logic          arstN,
    input  logic          wrEn,
    input  timestamp_t    data,
    output taggedSample_t sample,
    output logic          frameEnd
);

    // IDLE waits for a frame, COLLECT runs through the first pixels,
    // LAST holds the final pixel of the row
    typedef enum logic [1:0] {
        IDLE,
        COLLECT,
        LAST
    } seqState_t;

    seqState_t  state;
    seqState_t  stateNext;
    pixelIdx_t  pixelCnt;
    sampleIdx_t sampleCnt;
    logic       pixelDone;
    logic       frameDone;

    // registered copy of the tagged sample
    logic       sampleValid;
    pixelIdx_t  samplePixel;
    timestamp_t sampleStamp;

    // strobe carrying the last sample of the current pixel
    assign pixelDone = wrEn && (sampleCnt == sampleIdx_t'(SAMPLES_PER_PIXEL - 1));
    // and the last sample of the frame
    assign frameDone = pixelDone && (state == LAST);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                // first strobe opens a frame
                if (wrEn) begin
                    stateNext = COLLECT;
                end
            end
            COLLECT: begin
                // step into the final pixel
                if (pixelDone && pixelCnt == pixelIdx_t'(PIXEL_NUM - 2)) begin
                    stateNext = LAST;
                end
            end
            LAST: begin
                if (pixelDone) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= IDLE;
            pixelCnt    <= '0;
            sampleCnt   <= '0;
            sampleValid <= 1'b0;
            frameEnd    <= 1'b0;
        end else begin
            state       <= stateNext;
            sampleValid <= wrEn;
            // frame end rides along with the twelfth sample
            frameEnd    <= frameDone;
            if (wrEn) begin
                if (pixelDone) begin
                    sampleCnt <= '0;
                    // wrap back to pixel 0 after the row
                    pixelCnt  <= frameDone ? '0 : pixelCnt + 1'b1;
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (wrEn) begin
            samplePixel <= pixelCnt;
            sampleStamp <= data;
        end
    end

    assign sample = '{valid: sampleValid, pixel: samplePixel, stamp: sampleStamp};

    // tag handed to the histograms stays within the row
    pixelInRange: assert property (@(posedge clk) disable iff (!arstN)
        sample.valid |-> sample.pixel <= pixelIdx_t'(PIXEL_NUM - 1));

    // frame end only comes with a sample of the last pixel
    frameEndOnLast: assert property (@(posedge clk) disable iff (!arstN)
        frameEnd |-> sample.valid && sample.pixel == pixelIdx_t'(PIXEL_NUM - 1));

endmodule

/* hw/sifhBusPkg.sv */
package sifhBusPkg;

    import sifhParamsPkg::*;

    // one accepted timestamp on its way to the histograms
    // valid marks the single cycle in which it is counted
    typedef struct packed {
        logic       valid;
        pixelIdx_t  pixel;
        timestamp_t stamp;
    } taggedSample_t;

    // winning bin of one pixel
    // count is kept so the resolver can weigh the two histograms
    typedef struct packed {
        binIdx_t   bin;
        binCount_t count;
    } binWinner_t;

    // winners of the whole row, element p belongs to pixel p
    typedef binWinner_t [PIXEL_NUM-1:0] winnerSet_t;

    // resolved peak time per pixel
    typedef timestamp_t [PIXEL_NUM-1:0] peakSet_t;

endpackage

/* hw/sifhParamsPkg.sv */
package sifhParamsPkg;

    // timestamp width delivered by the TDC
    localparam int TIME_BITS = 10;
    // largest code a timestamp can hold
    localparam int TIME_MAX = (1 << TIME_BITS) - 1;

    // frame layout
    // pixels are sent one after the other, never interleaved
    localparam int PIXEL_NUM = 3;
    localparam int SAMPLES_PER_PIXEL = 4;

    // histogram geometry
    // bin width is a power of two so binning is a plain shift
    localparam int BIN_SHIFT = 7;
    localparam int BIN_WIDTH = 1 << BIN_SHIFT;
    // eight aligned bins cover the range, the ninth only fills when shifted
    localparam int BIN_NUM = 9;
    // offset of the shifted histogram, half a bin
    localparam int HALF_BIN = BIN_WIDTH / 2;

    // arrival time of one photon
    typedef logic [TIME_BITS-1:0] timestamp_t;

    // index into one pixel's bins
    typedef logic [$clog2(BIN_NUM)-1:0] binIdx_t;

    // hits per bin, wide enough for a whole pixel landing in one bin
    typedef logic [$clog2(SAMPLES_PER_PIXEL):0] binCount_t;

    // pixel within the row
    typedef logic [$clog2(PIXEL_NUM)-1:0] pixelIdx_t;

    // sample within one pixel's burst
    typedef logic [$clog2(SAMPLES_PER_PIXEL)-1:0] sampleIdx_t;

endpackage

/* hw/sifhTop.sv */
`timescale 1ns/10ps

module sifhTop
    import sifhParamsPkg::*;
    import sifhBusPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       wrEn,
    input  timestamp_t data,
    output peakSet_t   peakResult,
    output logic       peakValid
);

    // tagged stream feeding both histograms
    taggedSample_t sample;
    logic          frameEnd;

    // latched winners per histogram
    winnerSet_t alignedWin;
    winnerSet_t shiftedWin;

    sampleSequencer sampleSequencer_inst (
        .clk      (clk),
        .arstN    (arstN),
        .wrEn     (wrEn),
        .data     (data),
        .sample   (sample),
        .frameEnd (frameEnd)
    );

    // bins on 128 code edges
    binHistogram #(
        .BIN_OFFSET (0)
    ) alignedHist (
        .clk      (clk),
        .arstN    (arstN),
        .sample   (sample),
        .frameEnd (frameEnd),
        .winners  (alignedWin)
    );

    // same bins moved by half a bin, catches peaks across an aligned edge
    binHistogram #(
        .BIN_OFFSET (HALF_BIN)
    ) shiftedHist (
        .clk      (clk),
        .arstN    (arstN),
        .sample   (sample),
        .frameEnd (frameEnd),
        .winners  (shiftedWin)
    );

    peakResolver peakResolver_inst (
        .clk        (clk),
        .arstN      (arstN),
        .frameEnd   (frameEnd),
        .aligned    (alignedWin),
        .shifted    (shiftedWin),
        .peakResult (peakResult),
        .peakValid  (peakValid)
    );

endmodule

/* list.f */
hw/sifhParamsPkg.sv
hw/sifhBusPkg.sv
hw/sampleSequencer.sv
hw/binHistogram.sv
hw/peakResolver.sv
hw/sifhTop.sv
tests/sifhTopTb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module sifhTopTb -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }
simOut="$(./obj_dir/VsifhTopTb)" \
    || { echo "$simOut"; echo "simulation exited abnormally"; exit 1; }
echo "$simOut"
grep -qxF "Done: no errors" <<< "$simOut" && exit 0 || exit 1

/* tests/sifhTopTb.sv */
`timescale 1ns/10ps

module sifhTopTb
    import sifhParamsPkg::*;
    import sifhBusPkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 4;
    localparam int FRAME_LEN       = PIXEL_NUM * SAMPLES_PER_PIXEL;
    localparam int DIRECTED_NUM    = 4;
    localparam int FRAME_NUM       = 12;
    localparam int WATCHDOG_CYCLES = FRAME_NUM * 16 + 100;
    // last strobe at edge k gives peakValid after edge k+3
    localparam int RESULT_LATENCY  = 3;

    logic       clk;
    logic       arstN;
    logic       wrEn;
    timestamp_t data;
    peakSet_t   peakResult;
    logic       peakValid;

    // stimulus table, one row per frame
    int                   frameStamps [FRAME_NUM][FRAME_LEN];
    // bit i set puts one idle cycle before sample i
    logic [FRAME_LEN-1:0] gapMask     [FRAME_NUM];
    int                   expPeaks    [FRAME_NUM][PIXEL_NUM];

    logic [31:0] rngState;

    // frames whose result is still due, with the edge it is due at
    int pendFrame [$];
    int pendEdge  [$];
    int edgeCount   = 0;
    int strobeCount = 0;
    int valueErrors = 0;
    int protoErrors = 0;

    sifhTop sifhTop_inst (
        .clk        (clk),
        .arstN      (arstN),
        .wrEn       (wrEn),
        .data       (data),
        .peakResult (peakResult),
        .peakValid  (peakValid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // expected peaks of one frame straight from the binning rules
    function automatic void computePeaks(input int f);
        int alignedCnt [BIN_NUM];
        int shiftedCnt [BIN_NUM];
        int t;
        int aBin;
        int sBin;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                alignedCnt[b] = 0;
                shiftedCnt[b] = 0;
            end
            for (int s = 0; s < SAMPLES_PER_PIXEL; s++) begin
                t = frameStamps[f][p * SAMPLES_PER_PIXEL + s];
                alignedCnt[t / BIN_WIDTH] = alignedCnt[t / BIN_WIDTH] + 1;
                shiftedCnt[(t + HALF_BIN) / BIN_WIDTH] = shiftedCnt[(t + HALF_BIN) / BIN_WIDTH] + 1;
            end
            // highest count, lowest bin on ties
            aBin = 0;
            sBin = 0;
            for (int b = 1; b < BIN_NUM; b++) begin
                if (alignedCnt[b] > alignedCnt[aBin]) begin
                    aBin = b;
                end
                if (shiftedCnt[b] > shiftedCnt[sBin]) begin
                    sBin = b;
                end
            end
            // aligned centre unless the shifted bin holds strictly more
            if (alignedCnt[aBin] >= shiftedCnt[sBin]) begin
                expPeaks[f][p] = aBin * BIN_WIDTH + HALF_BIN;
            end else begin
                expPeaks[f][p] = (sBin * BIN_WIDTH > TIME_MAX) ? TIME_MAX : sBin * BIN_WIDTH;
            end
        end
    endfunction

    task automatic fillTable();
        logic [31:0] r;
        int centre;
        int spread;
        int t;
        // four equal samples per pixel
        frameStamps[0] = '{200, 200, 200, 200, 500, 500, 500, 500, 900, 900, 900, 900};
        gapMask[0]     = '0;
        // clusters across aligned edges at 128, 384, 640
        frameStamps[1] = '{126, 127, 128, 129, 382, 383, 384, 385, 638, 639, 640, 641};
        gapMask[1]     = '0;
        // top of range, 2/2 count tie, samples right below 1023
        frameStamps[2] = '{1020, 1021, 1022, 1023, 0, 10, 200, 250, 960, 961, 1000, 1023};
        gapMask[2]     = '0;
        // same kind of frame with idle cycles inside
        frameStamps[3] = '{700, 710, 720, 730, 50, 50, 60, 1000, 250, 260, 270, 5};
        gapMask[3]     = 12'h824;
        for (int f = DIRECTED_NUM; f < FRAME_NUM; f++) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                centre = int'(nextRandom() % 32'd1024);
                spread = int'(nextRandom() % 32'd20);
                for (int s = 0; s < SAMPLES_PER_PIXEL; s++) begin
                    t = centre + int'(nextRandom() % 32'(2 * spread + 1)) - spread;
                    t = (t < 0) ? 0 : ((t > TIME_MAX) ? TIME_MAX : t);
                    frameStamps[f][p * SAMPLES_PER_PIXEL + s] = t;
                end
            end
            r = nextRandom();
            // every other random frame gets a few idle cycles
            gapMask[f] = (f % 2 == 1) ? (r[FRAME_LEN-1:0] & 12'h222) : '0;
        end
        for (int f = 0; f < FRAME_NUM; f++) begin
            computePeaks(f);
        end
    endtask

    // called 2 ns after a rising edge, returns at the same point
    task automatic driveFrame(input int f);
        for (int i = 0; i < FRAME_LEN; i++) begin
            if (gapMask[f][i]) begin
                // garbage on data while wrEn is low
                wrEn = 1'b0;
                data = '1;
                @(posedge clk);
                #DRIVE_DELAY;
            end
            wrEn = 1'b1;
            data = timestamp_t'(frameStamps[f][i]);
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic checkOutputs();
        int f;
        int due;
        if (peakValid) begin
            assert (pendFrame.size() != 0) else begin
                protoErrors++;
                $display("Unexpected peakValid at %0t with no frame waiting for a result", $time);
            end
            if (pendFrame.size() != 0) begin
                f   = pendFrame.pop_front();
                due = pendEdge.pop_front();
                assert (due == edgeCount) else begin
                    protoErrors++;
                    $display("peakValid of frame %0d came at edge %0d instead of edge %0d",
                             f, edgeCount, due);
                end
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    assert (int'(peakResult[p]) == expPeaks[f][p]) else begin
                        valueErrors++;
                        $display("CHECK FAILED at %0t: frame %0d pixel %0d peak %0d expected %0d",
                                 $time, f, p, peakResult[p], expPeaks[f][p]);
                    end
                end
            end
        end else if (pendEdge.size() != 0 && pendEdge[0] <= edgeCount) begin
            f = pendFrame.pop_front();
            due = pendEdge.pop_front();
            assert (0) else begin
                protoErrors++;
                $display("No peakValid for frame %0d at edge %0d", f, due);
            end
        end
    endtask

    // strobes seen at the rising edge, outputs checked at the falling edge
    initial begin : monitor
        forever begin
            @(posedge clk);
            edgeCount++;
            if (arstN && wrEn) begin
                strobeCount++;
                if (strobeCount % FRAME_LEN == 0) begin
                    pendFrame.push_back(strobeCount / FRAME_LEN - 1);
                    pendEdge.push_back(edgeCount + RESULT_LATENCY);
                end
            end
            @(negedge clk);
            checkOutputs();
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin : mainSequence
        arstN    = 1'b0;
        wrEn     = 1'b0;
        data     = '0;
        rngState = 32'hcfa4885b;
        fillTable();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arstN = 1'b1;
        assert (!peakValid && peakResult == '0) else begin
            valueErrors++;
            $display("CHECK FAILED at %0t: outputs not cleared by reset", $time);
        end
        // idle after reset, any result here counts as extra
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        // frames back to back
        for (int f = 0; f < FRAME_NUM; f++) begin
            driveFrame(f);
        end
        wrEn = 1'b0;
        // drain the pipeline, then watch for stray pulses
        while (pendFrame.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("Errors: %0d wrong values, %0d missing, extra or mistimed results",
                 valueErrors, protoErrors);
        if (valueErrors + protoErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
